/* hw/bkg_pkg.sv */
`default_nettype none

package bkg_pkg;

    // background RAM geometry, two cells per byte
    localparam int RAM_AW = 12;             // byte address width, 4K bytes
    localparam int RAM_DW = 8;              // byte width
    localparam int CELL_W = 4;              // one background colour
    localparam int CPU_AW = RAM_AW + 1;     // cell address, msb picks the nibble

    // palette
    localparam int PAL_AW = 4;              // sixteen entries
    localparam int PAL_N  = 1 << PAL_AW;
    localparam int RGB_W  = 8;              // 3-3-2 rgb

    // CPU read-modify-write sequencer, one-hot
    typedef enum logic [2:0] {
        ST_ADDR  = 3'b001,  // address select, raster or cpu
        ST_WAIT  = 3'b010,  // ram read latency
        ST_WRITE = 3'b100   // merge nibble and write back
    } rmw_state_t;

endpackage

`default_nettype wire

/* hw/raster_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module raster_timing #(
    parameter int H_TOTAL = 256,    // pixels per line
    parameter int V_TOTAL = 264,    // lines per frame
    parameter int PXL_DIV = 2       // clk cycles per pixel
) (
    input  logic       clk,
    input  logic       rst_n,
    output logic       pxl_cen,
    output logic [8:0] hcount,
    output logic [8:0] vcount
);

    localparam int DIV_W = $clog2(PXL_DIV + 1);

    logic [DIV_W-1:0] div_cnt;
    logic             div_last;
    logic             h_last;
    logic             v_last;

    assign div_last = (div_cnt == DIV_W'(PXL_DIV - 1));
    assign h_last   = (hcount == 9'(H_TOTAL - 1));
    assign v_last   = (vcount == 9'(V_TOTAL - 1));

    // pixel enable divider
    // first enable lands PXL_DIV clk after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= div_last;
            if (div_last)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    // beam position, moves once per pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hcount <= '0;
                // next line only on hcount wrap
                if (v_last)
                    vcount <= '0;
                else
                    vcount <= vcount + 1'b1;
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/bkg_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module bkg_ram #(
    parameter int AW = 12,
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] addr,
    input  logic [DW-1:0] din,
    output logic [DW-1:0] dout
);

    logic [DW-1:0] mem [2**AW];   // no init, contents come from cpu

    // single port, one cycle read latency
    // read-before-write, dout shows old data on a write edge
    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= din;
        dout <= mem[addr];
    end

endmodule

`default_nettype wire

/* hw/bkg_layer.sv */
`timescale 1ns/10ps
`default_nettype none

module bkg_layer import bkg_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  logic [8:0]        hcount,
    input  logic [8:0]        vcount,
    input  logic              cpu_cs_n,        // level, low while cpu owns the ram
    input  logic              cpu_wr_strobe,   // write on rising edge
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [CELL_W-1:0] cpu_din,
    output logic [CELL_W-1:0] bkg_color
);

    // beam position latched per pixel
    logic [7:0] h_pos;
    logic [7:1] v_pos;

    // strobe edge
    logic wr_last;
    logic wr_edge;

    rmw_state_t state;

    logic [RAM_AW-1:0] cpu_byte;     // cpu byte address after half swap
    logic [RAM_AW-1:0] vid_byte;     // raster byte address
    logic              cpu_sel;

    logic [RAM_AW-1:0] ram_addr;
    logic [RAM_DW-1:0] ram_din;
    logic [RAM_DW-1:0] ram_dout;
    logic              ram_we;
    logic              nibble_sel;   // 1 = low nibble

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_pos <= '0;
            v_pos <= '0;
        end else if (pxl_cen) begin
            h_pos <= hcount[7:0];
            v_pos <= vcount[7:1];
        end
    end

    assign wr_edge = cpu_wr_strobe & ~wr_last;
    assign cpu_sel = ~cpu_cs_n;

    // board swaps the two address halves
    assign cpu_byte = {cpu_addr[5:0], cpu_addr[11:6]};
    // 64x64 bytes, four pixels per cell, one nibble per 128 lines
    assign vid_byte = {v_pos[6:1], h_pos[7:2]};

    // sequencer, idles in ST_ADDR
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_ADDR;
            wr_last <= 1'b0;
            ram_we  <= 1'b0;
        end else begin
            wr_last <= cpu_wr_strobe;
            case (state)
                ST_ADDR: begin
                    ram_we <= 1'b0;
                    if (wr_edge)
                        state <= ST_WAIT;
                end
                ST_WAIT: begin
                    state <= ST_WRITE;   // ram_dout valid next cycle
                end
                ST_WRITE: begin
                    ram_we <= 1'b1;      // one clk pulse
                    state  <= ST_ADDR;
                end
                default: begin
                    ram_we <= 1'b0;
                    state  <= ST_ADDR;
                end
            endcase
        end
    end

    // address and write data
    // address frozen from ST_WAIT until the write edge
    always_ff @(posedge clk) begin
        case (state)
            ST_ADDR: begin
                ram_addr   <= cpu_sel ? cpu_byte : vid_byte;
                nibble_sel <= cpu_sel ? ~cpu_addr[CPU_AW-1] : v_pos[7];
            end
            ST_WRITE: begin
                // replace only the chosen nibble
                if (nibble_sel)
                    ram_din <= {ram_dout[RAM_DW-1:CELL_W], cpu_din};
                else
                    ram_din <= {cpu_din, ram_dout[CELL_W-1:0]};
            end
            default: ;
        endcase
    end

    // colour of the group, taken on its last pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bkg_color <= '0;
        end else if (pxl_cen && h_pos[1:0] == 2'b11) begin
            bkg_color <= nibble_sel ? ram_dout[CELL_W-1:0]
                                    : ram_dout[RAM_DW-1:CELL_W];
        end
    end

    bkg_ram #(
        .AW (RAM_AW),
        .DW (RAM_DW)
    ) u_ram (
        .clk  (clk),
        .we   (ram_we),
        .addr (ram_addr),
        .din  (ram_din),
        .dout (ram_dout)
    );

endmodule

`default_nettype wire

/* hw/bkg_palette.sv */
`timescale 1ns/10ps
`default_nettype none

module bkg_palette import bkg_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,
    input  logic              pal_we,      // one clk strobe
    input  logic [PAL_AW-1:0] pal_addr,
    input  logic [RGB_W-1:0]  pal_data,
    input  logic [CELL_W-1:0] bkg_color,
    output logic [RGB_W-1:0]  rgb
);

    logic [RGB_W-1:0] pal_mem [PAL_N];   // 3-3-2 entries

    // cpu side, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PAL_N; i++)
                pal_mem[i] <= '0;
        end else if (pal_we) begin
            pal_mem[pal_addr] <= pal_data;
        end
    end

    // lookup, one pixel behind bkg_color
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rgb <= '0;
        else if (pxl_cen)
            rgb <= pal_mem[bkg_color];
    end

endmodule

`default_nettype wire

/* hw/bkg_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bkg_top import bkg_pkg::*; #(
    parameter int H_TOTAL = 256,
    parameter int V_TOTAL = 264,
    parameter int PXL_DIV = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    // cpu background port
    input  logic              cpu_cs_n,
    input  logic              cpu_wr_strobe,
    input  logic [CPU_AW-1:0] cpu_addr,
    input  logic [CELL_W-1:0] cpu_din,
    // palette port
    input  logic              pal_we,
    input  logic [PAL_AW-1:0] pal_addr,
    input  logic [RGB_W-1:0]  pal_data,
    // video out
    output logic              pxl_cen,
    output logic [8:0]        hcount,
    output logic [8:0]        vcount,
    output logic [CELL_W-1:0] bkg_color,
    output logic [RGB_W-1:0]  rgb
);

    raster_timing #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL),
        .PXL_DIV (PXL_DIV)
    ) u_timing (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .hcount  (hcount),
        .vcount  (vcount)
    );

    bkg_layer u_layer (
        .clk           (clk),
        .rst_n         (rst_n),
        .pxl_cen       (pxl_cen),
        .hcount        (hcount),
        .vcount        (vcount),
        .cpu_cs_n      (cpu_cs_n),
        .cpu_wr_strobe (cpu_wr_strobe),
        .cpu_addr      (cpu_addr),
        .cpu_din       (cpu_din),
        .bkg_color     (bkg_color)
    );

    bkg_palette u_palette (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .pal_we    (pal_we),
        .pal_addr  (pal_addr),
        .pal_data  (pal_data),
        .bkg_color (bkg_color),
        .rgb       (rgb)
    );

endmodule

`default_nettype wire

/* bench/bkg_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module bkg_chk import bkg_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input rmw_state_t        state,
    input logic              wr_edge,
    input logic              ram_we,
    input logic              pxl_cen,
    input logic [CELL_W-1:0] bkg_color
);

    state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state))
        else $error("rmw sequencer state is not one-hot");

    // strobe edge while idle always starts the sequence
    edge_to_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_ADDR && wr_edge) |=> state == ST_WAIT)
        else $error("ST_WAIT did not follow a strobe edge in ST_ADDR");

    we_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |-> $past(state == ST_WRITE))
        else $error("ram write enable outside the cycle after ST_WRITE");

    write_gives_we: assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_WRITE |=> ram_we)
        else $error("ST_WRITE not followed by a ram write");

    color_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !pxl_cen |=> $stable(bkg_color))   // moves only on a pixel enable
        else $error("bkg_color changed without a pixel enable");

endmodule

bind bkg_layer bkg_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .wr_edge   (wr_edge),
    .ram_we    (ram_we),
    .pxl_cen   (pxl_cen),
    .bkg_color (bkg_color)
);

`default_nettype wire

/* bench/tb_bkg.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_bkg import bkg_pkg::*; ();

    localparam int H_TOTAL   = 256;
    localparam int V_TOTAL   = 256;    // one frame reaches every cell
    localparam int PXL_DIV   = 2;
    localparam int FRAME_CLK = H_TOTAL * V_TOTAL * PXL_DIV;

    typedef enum logic [1:0] {OP_PAL, OP_CELL, OP_SCAN, OP_IDLE} op_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              cpu_cs_n;
    logic              cpu_wr_strobe;
    logic [CPU_AW-1:0] cpu_addr;
    logic [CELL_W-1:0] cpu_din;
    logic              pal_we;
    logic [PAL_AW-1:0] pal_addr;
    logic [RGB_W-1:0]  pal_data;
    logic              pxl_cen;
    logic [8:0]        hcount;
    logic [8:0]        vcount;
    logic [CELL_W-1:0] bkg_color;
    logic [RGB_W-1:0]  rgb;

    // stimulus table, one row per index
    op_t               op_q[$];
    logic [CPU_AW-1:0] addr_q[$];
    logic [7:0]        data_q[$];     // nibble, palette entry or idle clk
    string             name_q[$];

    logic [RAM_DW-1:0] ram_model [1 << RAM_AW];   // byte image of the bkg ram
    logic [RGB_W-1:0]  pal_model [PAL_N];
    int unsigned       lcg_state = 76;

    always #4 clk = ~clk;   // 8 ns period

    bkg_top #(.V_TOTAL(V_TOTAL)) dut (
        .clk(clk), .rst_n(rst_n),
        .cpu_cs_n(cpu_cs_n), .cpu_wr_strobe(cpu_wr_strobe),
        .cpu_addr(cpu_addr), .cpu_din(cpu_din),
        .pal_we(pal_we), .pal_addr(pal_addr), .pal_data(pal_data),
        .pxl_cen(pxl_cen), .hcount(hcount), .vcount(vcount),
        .bkg_color(bkg_color), .rgb(rgb)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;   // upper bits, better period
    endfunction

    // init pattern, every address bit matters
    function automatic logic [3:0] fill_cell(logic [12:0] a);
        return a[3:0] ^ a[7:4] ^ a[11:8] ^ {a[12], 3'b101};
    endfunction

    // random nibble, never equal to the fill value at a
    function automatic logic [3:0] changed_nibble(logic [12:0] a);
        return fill_cell(a) ^ 4'(lcg_next() | 1);
    endfunction

    // colour expected for beam position h, v
    function automatic logic [3:0] cell_model(int h, int v);
        logic [7:0] b;
        b = ram_model[{v[6:1], h[7:2]}];
        return v[7] ? b[3:0] : b[7:4];   // lower half of the screen uses low nibble
    endfunction

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("ERR %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
        $display("test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic add_step(op_t op, logic [12:0] a, logic [7:0] d, string name);
        op_q.push_back(op);
        addr_q.push_back(a);
        data_q.push_back(d);
        name_q.push_back(name);
    endtask

    // cs low, strobe edge, cs held past the ST_WRITE edge
    task automatic cpu_write(logic [12:0] a, logic [3:0] d);
        @(negedge clk);
        cpu_cs_n = 1'b0;
        cpu_addr = a;
        cpu_din  = d;
        @(negedge clk);
        cpu_wr_strobe = 1'b1;
        repeat (5) @(negedge clk);
        cpu_wr_strobe = 1'b0;
        cpu_cs_n      = 1'b1;
    endtask

    // one frame of pixels, colour at hcount%4==1, rgb one pixel later
    task automatic scan_frame(string name);
        int         seen;
        int         h_prev;
        int         v_prev;
        logic [3:0] exp_color;
        logic       have_color;
        seen       = 0;
        have_color = 1'b0;
        exp_color  = '0;
        while (seen < 8 + H_TOTAL * V_TOTAL) begin
            @(negedge clk);
            if (pxl_cen) begin
                seen++;
                if (seen > 8 && hcount[1:0] == 2'd1) begin   // skip groups near the cpu window
                    h_prev = (hcount + H_TOTAL - 4) % H_TOTAL;
                    v_prev = (hcount < 4) ? (vcount + V_TOTAL - 1) % V_TOTAL : vcount;
                    exp_color = cell_model(h_prev, v_prev);
                    assert (bkg_color === exp_color)
                        else report_mismatch(name, exp_color, bkg_color);
                    have_color = 1'b1;
                end else if (have_color && hcount[1:0] == 2'd2) begin
                    assert (rgb === pal_model[exp_color])
                        else report_mismatch({name, "_rgb"}, pal_model[exp_color], rgb);
                end
            end
        end
    endtask

    // free-running beam model, started right after reset release
    task automatic raster_watch();
        int h_exp;
        int v_exp;
        int since;
        h_exp = 0;
        v_exp = 0;
        since = 0;
        forever begin
            @(negedge clk);
            since++;
            if (pxl_cen) begin
                assert (since == PXL_DIV) else report_mismatch("pxl_cen_period", PXL_DIV, since);
                assert (hcount == h_exp) else report_mismatch("hcount", h_exp, hcount);
                assert (vcount == v_exp) else report_mismatch("vcount", v_exp, vcount);
                since = 0;
                if (h_exp == H_TOTAL - 1) begin
                    h_exp = 0;
                    v_exp = (v_exp == V_TOTAL - 1) ? 0 : v_exp + 1;
                end else begin
                    h_exp++;
                end
            end
        end
    endtask

    task automatic build_table();
        for (int a = 0; a < (1 << CPU_AW); a++)   // both nibbles of every byte
            add_step(OP_CELL, CPU_AW'(a), {4'h0, fill_cell(CPU_AW'(a))}, "fill");
        add_step(OP_SCAN, '0, '0, "scan_fill");
        for (int p = 0; p < PAL_N; p++)
            add_step(OP_PAL, CPU_AW'(p), 8'(lcg_next()), "palette");
        add_step(OP_CELL, 13'h0123, {4'h0, changed_nibble(13'h0123)}, "low_nibble");
        add_step(OP_SCAN, '0, '0, "scan_low");
        add_step(OP_CELL, 13'h1456, {4'h0, changed_nibble(13'h1456)}, "high_nibble");
        add_step(OP_CELL, 13'h0456, {4'h0, changed_nibble(13'h0456)}, "low_after_high");
        add_step(OP_SCAN, '0, '0, "scan_both");
        for (int r = 0; r < 48; r++)
            add_step(OP_CELL, CPU_AW'(lcg_next()), 8'(lcg_next() & 15), "random");
        add_step(OP_IDLE, '0, 8'd40, "idle");
        add_step(OP_SCAN, '0, '0, "scan_random");
    endtask

    initial begin
        int n_scan;
        int limit;
        rst_n         = 1'b0;
        cpu_cs_n      = 1'b1;
        cpu_wr_strobe = 1'b0;
        cpu_addr      = '0;
        cpu_din       = '0;
        pal_we        = 1'b0;
        pal_addr      = '0;
        pal_data      = '0;
        for (int i = 0; i < PAL_N; i++)
            pal_model[i] = '0;   // palette clears on reset
        build_table();
        n_scan = 0;
        foreach (op_q[i])
            if (op_q[i] == OP_SCAN)
                n_scan++;
        limit = n_scan * (FRAME_CLK + 16 * PXL_DIV) + (op_q.size() - n_scan) * 100 + 2000;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("timeout: run did not finish within %0d clock cycles", limit);
                $display("test failed");
                $fatal(1, "watchdog expired");
            end
        join_none
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        fork
            raster_watch();
        join_none
        assert (bkg_color === '0) else report_mismatch("reset_color", 0, bkg_color);
        assert (rgb === '0) else report_mismatch("reset_rgb", 0, rgb);
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                OP_PAL: begin
                    @(negedge clk);
                    pal_we   = 1'b1;
                    pal_addr = addr_q[i][PAL_AW-1:0];
                    pal_data = data_q[i];
                    @(negedge clk);
                    pal_we = 1'b0;
                    pal_model[addr_q[i][PAL_AW-1:0]] = data_q[i];
                end
                OP_CELL: begin
                    cpu_write(addr_q[i], data_q[i][3:0]);
                    // half swap, bit 12 picks the nibble
                    if (addr_q[i][12])
                        ram_model[{addr_q[i][5:0], addr_q[i][11:6]}][7:4] = data_q[i][3:0];
                    else
                        ram_model[{addr_q[i][5:0], addr_q[i][11:6]}][3:0] = data_q[i][3:0];
                end
                OP_SCAN: scan_frame(name_q[i]);
                default: repeat (data_q[i]) @(negedge clk);
            endcase
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hw/bkg_pkg.sv
hw/raster_timing.sv
hw/bkg_ram.sv
hw/bkg_layer.sv
hw/bkg_palette.sv
hw/bkg_top.sv
bench/bkg_chk.sv
bench/tb_bkg.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_bkg -f all.f -o tb_bkg
./obj_dir/tb_bkg > sim.log 2>&1 || true
cat sim.log
if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    exit 1
fi
exit 0
